// File: fused_defs.svh
`ifndef FUSED_DEFS_SVH
`define FUSED_DEFS_SVH

`define FUSED_WORD_W      32  // Memory word
`define FUSED_LANES       4   // int8 channels per word
`define FUSED_KERNEL      3
`define FUSED_L1_FILTERS  16
`define FUSED_L2_FILTERS  4
`define FUSED_L1_WORDS    4   // Packed words per layer-1 pixel
`define FUSED_ACC_W       24

`define FUSED_ACT_SHIFT   4   // Q4 scaling before clamp
`define FUSED_RELU6_MAX   96  // 6.0 in Q4

`define FUSED_IFM_W_MIN   4
`define FUSED_IFM_W_MAX   8
`define FUSED_IFM_DEPTH   64

`endif

// File: fused_pkg.sv
`include "fused_defs.svh"

package fused_pkg;

    typedef logic [`FUSED_WORD_W-1:0]                     word_t;     // Lane 0 in low byte
    typedef logic signed [7:0]                            data_t;
    typedef logic signed [`FUSED_ACC_W-1:0]               acc_t;
    typedef logic [3:0]                                   dim_t;      // Feature map width
    typedef logic [5:0]                                   pix_idx_t;
    typedef logic [`FUSED_L2_FILTERS*`FUSED_ACC_W-1:0]    res_t;      // Filter 0 low

    typedef enum logic [1:0] {
        MEM_IFM,
        MEM_W1,
        MEM_W2
    } mem_sel_t;

    typedef enum logic [1:0] {
        S_IDLE, S_RUN, S_DRAIN, S_ACK
    } seq_state_t;

    typedef enum logic [1:0] {P_IDLE, P_READ, P_LAST} pw_state_t;

endpackage

// File: lane_ram.sv
`timescale 1ns/10ps
`include "fused_defs.svh"

module lane_ram #(
    parameter int LANES = 4,
    parameter int DEPTH = 9
) (
    input  logic                            clk,
    input  logic                            we,
    input  logic [3:0]                      wr_lane,
    input  fused_pkg::pix_idx_t             wr_addr,
    input  fused_pkg::word_t                wr_data,
    input  fused_pkg::pix_idx_t             rd_addr,
    output logic [LANES*`FUSED_WORD_W-1:0]  rd_data
);
    import fused_pkg::*;

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        word_t mem [DEPTH];

        always_ff @(posedge clk) begin
            if (we && wr_lane == 4'(l) && int'(wr_addr) < DEPTH) begin
                mem[wr_addr[AW-1:0]] <= wr_data;
            end
            rd_data[l*`FUSED_WORD_W +: `FUSED_WORD_W] <= mem[rd_addr[AW-1:0]];  // Shared read index
        end
    end

endmodule

// File: conv3x3_sequencer.sv
`timescale 1ns/10ps
`include "fused_defs.svh"

module conv3x3_sequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req,
    input  fused_pkg::dim_t      ifm_w,
    input  logic                 res_valid,
    output logic                 ack,
    output fused_pkg::pix_idx_t  ifm_rd_addr,
    output fused_pkg::pix_idx_t  w1_rd_addr,
    output logic                 mac_en,
    output logic                 mac_clear,
    output logic                 mac_last
);
    import fused_pkg::*;

    localparam logic [1:0] TAP_LAST = 2'(`FUSED_KERNEL - 1);

    seq_state_t state;
    dim_t       oy;
    dim_t       ox;
    logic [1:0] ky;
    logic [1:0] kx;
    pix_idx_t   beat_cnt;
    dim_t       ofm_w;
    dim_t       last_pos;
    pix_idx_t   total;
    pix_idx_t   row;
    pix_idx_t   col;
    logic       tap_first;
    logic       tap_last;
    logic       pix_last;

    assign ofm_w    = ifm_w - dim_t'(`FUSED_KERNEL - 1);  // No padding
    assign last_pos = ofm_w - 4'd1;
    assign total    = pix_idx_t'(ofm_w) * pix_idx_t'(ofm_w);

    assign row         = pix_idx_t'(oy) + pix_idx_t'(ky);
    assign col         = pix_idx_t'(ox) + pix_idx_t'(kx);
    assign ifm_rd_addr = row * pix_idx_t'(ifm_w) + col;
    assign w1_rd_addr  = pix_idx_t'(ky) * pix_idx_t'(`FUSED_KERNEL) + pix_idx_t'(kx);

    assign tap_first = (ky == 2'd0) && (kx == 2'd0);
    assign tap_last  = (ky == TAP_LAST) && (kx == TAP_LAST);
    assign pix_last  = tap_last && (ox == last_pos) && (oy == last_pos);
    assign ack       = (state == S_ACK);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            oy    <= '0;
            ox    <= '0;
            ky    <= '0;
            kx    <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req) begin
                        state <= S_RUN;
                        oy    <= '0;
                        ox    <= '0;
                        ky    <= '0;
                        kx    <= '0;
                    end
                end
                S_RUN: begin
                    if (pix_last) state <= S_DRAIN;  // Final tap issued
                    if (kx != TAP_LAST) begin
                        kx <= kx + 2'd1;
                    end else begin
                        kx <= '0;
                        if (ky != TAP_LAST) begin
                            ky <= ky + 2'd1;
                        end else begin
                            ky <= '0;
                            if (ox != last_pos) begin
                                ox <= ox + 4'd1;
                            end else begin
                                ox <= '0;
                                oy <= oy + 4'd1;
                            end
                        end
                    end
                end
                S_DRAIN: if (beat_cnt == total) state <= S_ACK;
                S_ACK:   if (!req) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // Result beats of the current job
    always_ff @(posedge clk) begin
        if (reset || state == S_IDLE) beat_cnt <= '0;
        else if (res_valid)           beat_cnt <= beat_cnt + 6'd1;
    end

    // One cycle late to meet the registered RAM reads
    always_ff @(posedge clk) begin
        if (reset) begin
            mac_en    <= 1'b0;
            mac_clear <= 1'b0;
            mac_last  <= 1'b0;
        end else begin
            mac_en    <= (state == S_RUN);
            mac_clear <= (state == S_RUN) && tap_first;
            mac_last  <= (state == S_RUN) && tap_last;
        end
    end

endmodule

// File: pe_array.sv
`timescale 1ns/10ps
`include "fused_defs.svh"

module pe_array #(
    parameter int NUM_PE = 16
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             mac_en,
    input  logic                             mac_clear,
    input  logic                             mac_last,
    input  fused_pkg::word_t                 ifm_word,
    input  logic [NUM_PE*`FUSED_WORD_W-1:0]  weights,
    output logic [NUM_PE*`FUSED_ACC_W-1:0]   acc_out,
    output logic                             acc_out_valid
);
    import fused_pkg::*;

    for (genvar p = 0; p < NUM_PE; p++) begin : g_pe
        acc_t dot;
        acc_t acc;
        acc_t sum;

        // Signed int8 dot product over the word lanes
        always_comb begin
            logic signed [15:0] prod;
            dot = '0;
            for (int i = 0; i < `FUSED_LANES; i++) begin
                prod = data_t'(ifm_word[8*i +: 8]) *
                       data_t'(weights[p*`FUSED_WORD_W + 8*i +: 8]);
                dot  = dot + acc_t'(prod);
            end
        end

        assign sum = mac_clear ? dot : acc + dot;  // Clear restarts with this product

        always_ff @(posedge clk) begin
            if (mac_en) acc <= sum;
            if (mac_en && mac_last) acc_out[p*`FUSED_ACC_W +: `FUSED_ACC_W] <= sum;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) acc_out_valid <= 1'b0;
        else       acc_out_valid <= mac_en && mac_last;
    end

endmodule

// File: act_buffer.sv
`timescale 1ns/10ps
`include "fused_defs.svh"

module act_buffer (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic [`FUSED_L1_FILTERS*`FUSED_ACC_W-1:0]     acc_in,
    input  logic                                          acc_in_valid,
    input  logic                                          rd_slot,
    input  logic [1:0]                                    rd_word,
    output fused_pkg::word_t                              rd_data,
    output logic                                          slot_ready,
    output logic                                          ready_slot
);
    import fused_pkg::*;

    localparam logic [1:0] WORD_LAST = 2'(`FUSED_L1_WORDS - 1);

    logic [`FUSED_L1_FILTERS*8-1:0] act_reg;  // Channel c in byte c
    word_t      store [2*`FUSED_L1_WORDS];
    logic       packing;
    logic [1:0] pack_cnt;
    logic       wr_slot;
    logic       parity;

    function automatic data_t relu6(acc_t a);
        acc_t s;
        s = a >>> `FUSED_ACT_SHIFT;
        if (s < 0)                     return '0;
        else if (s > `FUSED_RELU6_MAX) return data_t'(`FUSED_RELU6_MAX);
        else                           return data_t'(s);
    endfunction

    always_ff @(posedge clk) begin
        if (acc_in_valid) begin
            for (int c = 0; c < `FUSED_L1_FILTERS; c++) begin
                act_reg[8*c +: 8] <= relu6(acc_in[c*`FUSED_ACC_W +: `FUSED_ACC_W]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            packing    <= 1'b0;
            pack_cnt   <= '0;
            wr_slot    <= 1'b0;
            parity     <= 1'b0;
            slot_ready <= 1'b0;
            ready_slot <= 1'b0;
        end else begin
            slot_ready <= packing && (pack_cnt == WORD_LAST);
            if (acc_in_valid) begin
                packing  <= 1'b1;
                pack_cnt <= '0;
                wr_slot  <= parity;      // Alternate slots per pixel
                parity   <= ~parity;
            end else if (packing) begin
                pack_cnt <= pack_cnt + 2'd1;
                if (pack_cnt == WORD_LAST) begin
                    packing    <= 1'b0;
                    ready_slot <= wr_slot;
                end
            end
        end
    end

    // 4:1 pack into the store, registered read for layer 2
    always_ff @(posedge clk) begin
        if (packing) store[{wr_slot, pack_cnt}] <= act_reg[`FUSED_WORD_W*pack_cnt +: `FUSED_WORD_W];
        rd_data <= store[{rd_slot, rd_word}];
    end

endmodule

// File: pointwise_ctrl.sv
`timescale 1ns/10ps
`include "fused_defs.svh"

module pointwise_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 slot_ready,
    input  logic                 ready_slot,
    input  fused_pkg::res_t      acc_in,
    input  logic                 acc_in_valid,
    output logic                 rd_slot,
    output logic [1:0]           rd_word,
    output fused_pkg::pix_idx_t  w2_rd_addr,
    output logic                 mac_en,
    output logic                 mac_clear,
    output logic                 mac_last,
    output logic                 res_valid,
    output fused_pkg::res_t      res_data
);
    import fused_pkg::*;

    pw_state_t  state;
    logic [1:0] cnt;
    logic       slot_q;

    assign rd_slot    = slot_q;
    assign rd_word    = cnt;
    assign w2_rd_addr = pix_idx_t'(cnt);  // Input channels 4k..4k+3

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= P_IDLE;
            cnt       <= '0;
            slot_q    <= 1'b0;
            mac_en    <= 1'b0;
            mac_clear <= 1'b0;
            mac_last  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            case (state)
                P_IDLE: if (slot_ready) begin
                    state  <= P_READ;
                    cnt    <= '0;
                    slot_q <= ready_slot;
                end
                P_READ: begin
                    cnt <= cnt + 2'd1;
                    if (cnt == 2'(`FUSED_L1_WORDS - 2)) state <= P_LAST;
                end
                default: state <= P_IDLE;
            endcase
            mac_en    <= (state != P_IDLE);  // Aligned to the read latency
            mac_clear <= (state == P_READ) && (cnt == 2'd0);
            mac_last  <= (state == P_LAST);
            res_valid <= acc_in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (acc_in_valid) res_data <= acc_in;
    end

endmodule

// File: fused_conv_top.sv
`timescale 1ns/10ps
`include "fused_defs.svh"

module fused_conv_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req,
    output logic                 ack,
    input  fused_pkg::dim_t      ifm_w,
    input  logic                 load_we,
    input  fused_pkg::mem_sel_t  load_sel,
    input  logic [3:0]           load_lane,
    input  fused_pkg::pix_idx_t  load_addr,
    input  fused_pkg::word_t     load_data,
    output logic                 res_valid,
    output fused_pkg::res_t      res_data
);
    import fused_pkg::*;

    logic we_ifm;
    logic we_w1;
    logic we_w2;
    word_t    ifm_word;
    logic [`FUSED_L1_FILTERS*`FUSED_WORD_W-1:0] w1_words;
    logic [`FUSED_L2_FILTERS*`FUSED_WORD_W-1:0] w2_words;
    pix_idx_t ifm_rd_addr;
    pix_idx_t w1_rd_addr;
    pix_idx_t w2_rd_addr;
    logic     l1_en, l1_clear, l1_last;
    logic [`FUSED_L1_FILTERS*`FUSED_ACC_W-1:0]  l1_acc;
    logic     l1_acc_valid;
    word_t    act_word;
    logic     rd_slot;
    logic [1:0] rd_word;
    logic     slot_ready;
    logic     ready_slot;
    logic     l2_en, l2_clear, l2_last;
    res_t     l2_acc;
    logic     l2_acc_valid;

    assign we_ifm = load_we && (load_sel == MEM_IFM);
    assign we_w1  = load_we && (load_sel == MEM_W1);
    assign we_w2  = load_we && (load_sel == MEM_W2);

    lane_ram #(.LANES(1), .DEPTH(`FUSED_IFM_DEPTH)) u_ifm_ram (
        .clk(clk), .we(we_ifm), .wr_lane(load_lane), .wr_addr(load_addr),
        .wr_data(load_data), .rd_addr(ifm_rd_addr), .rd_data(ifm_word));

    lane_ram #(.LANES(`FUSED_L1_FILTERS), .DEPTH(`FUSED_KERNEL*`FUSED_KERNEL)) u_w1_ram (
        .clk(clk), .we(we_w1), .wr_lane(load_lane), .wr_addr(load_addr),
        .wr_data(load_data), .rd_addr(w1_rd_addr), .rd_data(w1_words));

    lane_ram #(.LANES(`FUSED_L2_FILTERS), .DEPTH(`FUSED_L1_WORDS)) u_w2_ram (
        .clk(clk), .we(we_w2), .wr_lane(load_lane), .wr_addr(load_addr),
        .wr_data(load_data), .rd_addr(w2_rd_addr), .rd_data(w2_words));

    conv3x3_sequencer u_seq (
        .clk(clk), .reset(reset), .req(req), .ifm_w(ifm_w), .res_valid(res_valid),
        .ack(ack), .ifm_rd_addr(ifm_rd_addr), .w1_rd_addr(w1_rd_addr),
        .mac_en(l1_en), .mac_clear(l1_clear), .mac_last(l1_last));

    pe_array #(.NUM_PE(`FUSED_L1_FILTERS)) u_pe_l1 (
        .clk(clk), .reset(reset), .mac_en(l1_en), .mac_clear(l1_clear), .mac_last(l1_last),
        .ifm_word(ifm_word), .weights(w1_words), .acc_out(l1_acc),
        .acc_out_valid(l1_acc_valid));

    act_buffer u_act_buf (
        .clk(clk), .reset(reset), .acc_in(l1_acc), .acc_in_valid(l1_acc_valid),
        .rd_slot(rd_slot), .rd_word(rd_word), .rd_data(act_word),
        .slot_ready(slot_ready), .ready_slot(ready_slot));

    pe_array #(.NUM_PE(`FUSED_L2_FILTERS)) u_pe_l2 (
        .clk(clk), .reset(reset), .mac_en(l2_en), .mac_clear(l2_clear), .mac_last(l2_last),
        .ifm_word(act_word), .weights(w2_words), .acc_out(l2_acc),
        .acc_out_valid(l2_acc_valid));

    pointwise_ctrl u_pw_ctrl (
        .clk(clk), .reset(reset), .slot_ready(slot_ready), .ready_slot(ready_slot),
        .acc_in(l2_acc), .acc_in_valid(l2_acc_valid), .rd_slot(rd_slot), .rd_word(rd_word),
        .w2_rd_addr(w2_rd_addr), .mac_en(l2_en), .mac_clear(l2_clear), .mac_last(l2_last),
        .res_valid(res_valid), .res_data(res_data));

endmodule

// File: tb_fused_conv.sv
`timescale 1ns/10ps
`include "fused_defs.svh"

module tb_fused_conv;
    import fused_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int RAND_JOBS    = 7;  // Jobs whose width is drawn at random
    localparam int MODE_RAND    = 0;
    localparam int MODE_POS     = 1;  // Every byte 64..127
    localparam int MODE_NEG     = 2;  // Every byte -128..-1

    logic       clk;
    logic       reset;
    logic       req;
    logic       ack;
    dim_t       ifm_w;
    logic       load_we;
    mem_sel_t   load_sel;
    logic [3:0] load_lane;
    pix_idx_t   load_addr;
    word_t      load_data;
    logic       res_valid;
    res_t       res_data;

    logic [15:0] lfsr = 16'd37035;
    word_t ifm_m [`FUSED_IFM_DEPTH];
    word_t w1_m  [`FUSED_L1_FILTERS][`FUSED_KERNEL*`FUSED_KERNEL];
    word_t w2_m  [`FUSED_L2_FILTERS][`FUSED_L1_WORDS];
    res_t  exp_q [$];  // Expected beats, raster order
    int    beats;
    int    errors;
    int    err_mark;
    int    tests_run;
    int    tests_failed;
    string cur_test;

    fused_conv_top u_fused_conv_top (
        .clk(clk), .reset(reset), .req(req), .ack(ack), .ifm_w(ifm_w),
        .load_we(load_we), .load_sel(load_sel), .load_lane(load_lane),
        .load_addr(load_addr), .load_data(load_data),
        .res_valid(res_valid), .res_data(res_data));

    always #50 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic int rand_width();
        return `FUSED_IFM_W_MIN + int'(rand_bits(3) % 5);
    endfunction

    function automatic word_t make_word(int mode);
        word_t w;
        w = rand_bits(32);
        for (int i = 0; i < `FUSED_LANES; i++) begin
            if (mode == MODE_POS) w[8*i+6 +: 2] = 2'b01;
            else if (mode == MODE_NEG) w[8*i+7] = 1'b1;
        end
        return w;
    endfunction

    function automatic int lane_val(word_t w, int i);
        data_t d;
        d = w[8*i +: 8];
        return int'(d);
    endfunction

    function automatic int relu6(int s);
        int q;
        q = s >>> `FUSED_ACT_SHIFT;
        if (q < 0) return 0;
        if (q > `FUSED_RELU6_MAX) return `FUSED_RELU6_MAX;
        return q;
    endfunction

    // Both layers for one output pixel
    function automatic res_t model_pixel(int w, int oy, int ox);
        int   act [`FUSED_L1_FILTERS];
        int   sum;
        word_t px;
        res_t r;
        for (int f = 0; f < `FUSED_L1_FILTERS; f++) begin
            sum = 0;
            for (int ky = 0; ky < `FUSED_KERNEL; ky++) begin
                for (int kx = 0; kx < `FUSED_KERNEL; kx++) begin
                    px = ifm_m[(oy + ky) * w + ox + kx];
                    for (int c = 0; c < `FUSED_LANES; c++) begin
                        sum += lane_val(px, c) * lane_val(w1_m[f][ky*`FUSED_KERNEL + kx], c);
                    end
                end
            end
            act[f] = relu6(sum);
        end
        for (int g = 0; g < `FUSED_L2_FILTERS; g++) begin
            sum = 0;
            for (int ch = 0; ch < `FUSED_L1_FILTERS; ch++) begin
                sum += act[ch] * lane_val(w2_m[g][ch / 4], ch % 4);  // Word k holds 4k..4k+3
            end
            r[`FUSED_ACC_W*g +: `FUSED_ACC_W] = acc_t'(sum);
        end
        return r;
    endfunction

    function automatic int job_budget(int w);
        return 200 + 20 * (w - 2) * (w - 2);
    endfunction

    task automatic check_res(string name, res_t exp, res_t act);
        if (act !== exp) begin
            $display("mismatch %s result: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(string name, pix_idx_t exp, pix_idx_t act);
        if (act !== exp) begin
            $display("mismatch %s beat count: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic write_word(mem_sel_t sel, int lane, int addr, word_t data);
        @(negedge clk);
        load_we   = 1'b1;
        load_sel  = sel;
        load_lane = 4'(lane);
        load_addr = pix_idx_t'(addr);
        load_data = data;
    endtask

    task automatic end_load();
        @(negedge clk);
        load_we = 1'b0;
    endtask

    task automatic load_ifm(int words, int mode);
        for (int a = 0; a < words; a++) begin
            ifm_m[a] = make_word(mode);
            write_word(MEM_IFM, 0, a, ifm_m[a]);
        end
        end_load();
    endtask

    task automatic load_w1(int mode);
        for (int f = 0; f < `FUSED_L1_FILTERS; f++) begin
            for (int t = 0; t < `FUSED_KERNEL*`FUSED_KERNEL; t++) begin
                w1_m[f][t] = make_word(mode);
                write_word(MEM_W1, f, t, w1_m[f][t]);
            end
        end
        end_load();
    endtask

    task automatic load_w2();
        for (int g = 0; g < `FUSED_L2_FILTERS; g++) begin
            for (int k = 0; k < `FUSED_L1_WORDS; k++) begin
                w2_m[g][k] = make_word(MODE_RAND);
                write_word(MEM_W2, g, k, w2_m[g][k]);
            end
        end
        end_load();
    endtask

    task automatic run_job(int w);
        int npix;
        npix = (w - 2) * (w - 2);
        for (int oy = 0; oy < w - 2; oy++) begin
            for (int ox = 0; ox < w - 2; ox++) begin
                exp_q.push_back(model_pixel(w, oy, ox));
            end
        end
        beats = 0;
        @(negedge clk);
        ifm_w = dim_t'(w);
        req   = 1'b1;
        while (!ack) @(negedge clk);
        check_count(cur_test, pix_idx_t'(npix), pix_idx_t'(beats));
        if (exp_q.size() != 0) begin
            $display("%s: ack came with %0d beats still missing", cur_test, exp_q.size());
            errors++;
            exp_q.delete();
        end
        req = 1'b0;
        @(negedge clk);
        if (ack !== 1'b0) begin
            $display("%s: ack stayed high one cycle after req dropped", cur_test);
            errors++;
        end
        while (ack) @(negedge clk);
    endtask

    task automatic start_test(string name);
        cur_test = name;
        err_mark = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors != err_mark) begin
            tests_failed++;
            $display("%s: failed with %0d errors", cur_test, errors - err_mark);
        end else begin
            $display("%s: passed", cur_test);
        end
    endtask

    // Outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (!reset && res_valid) begin
            beats++;
            if (exp_q.size() == 0) begin
                $display("%s: result beat arrived when none was expected", cur_test);
                errors++;
            end else begin
                check_res(cur_test, exp_q.pop_front(), res_data);
            end
        end
    end

    initial begin
        int limit;
        limit = RESET_CYCLES + job_budget(4) + RAND_JOBS * job_budget(`FUSED_IFM_W_MAX);
        for (int w = `FUSED_IFM_W_MIN; w <= `FUSED_IFM_W_MAX; w++) limit += job_budget(w);
        repeat (limit) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", limit);
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        int w;
        clk       = 1'b0;
        reset     = 1'b1;
        req       = 1'b0;
        ifm_w     = dim_t'(`FUSED_IFM_W_MIN);
        load_we   = 1'b0;
        load_sel  = MEM_IFM;
        load_lane = '0;
        load_addr = '0;
        load_data = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cur_test     = "reset";
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        start_test("reset_handshake");
        if (ack !== 1'b0 || res_valid !== 1'b0) begin
            $display("%s: ack or res_valid not low after reset", cur_test);
            errors++;
        end
        load_ifm(16, MODE_RAND);
        load_w1(MODE_RAND);
        load_w2();
        run_job(4);
        finish_test();

        start_test("random_widths");
        for (int i = `FUSED_IFM_W_MIN; i <= `FUSED_IFM_W_MAX; i++) begin
            load_ifm(i * i, MODE_RAND);
            load_w1(MODE_RAND);
            load_w2();
            run_job(i);
        end
        finish_test();

        start_test("saturation");
        w = rand_width();
        load_ifm(w * w, MODE_POS);
        load_w1(MODE_POS);  // All activations at 96
        load_w2();
        run_job(w);
        load_w1(MODE_NEG);  // All activations at 0
        run_job(w);
        finish_test();

        start_test("weight_reload");
        w = rand_width();
        load_ifm(w * w, MODE_RAND);
        load_w1(MODE_RAND);
        load_w2();
        run_job(w);
        load_w2();
        run_job(w);
        finish_test();

        start_test("back_to_back");
        load_ifm(`FUSED_IFM_DEPTH, MODE_RAND);
        repeat (3) run_job(rand_width());
        repeat (40) @(negedge clk);  // Stray beats would land here
        finish_test();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+.
fused_pkg.sv
lane_ram.sv
conv3x3_sequencer.sv
pe_array.sv
act_buffer.sv
pointwise_ctrl.sv
fused_conv_top.sv
tb_fused_conv.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the fused convolution testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_fused_conv -f verilog.f -o vtb_fused_conv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/vtb_fused_conv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
    exit 1
fi
exit 0
